/* flist.f */
logic/lsu_pkg.sv
logic/lsu_sequencer.sv
logic/lsu_request.sv
logic/lsu_writeback.sv
logic/lsu_top.sv
testbench/tb_clock_gen.sv
testbench/tb_lsu.sv

/* run.sh */
#!/bin/sh
# build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_lsu -f flist.f -o sim_lsu
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/sim_lsu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
    exit 0
else
    exit 1
fi

/* testbench/tb_lsu.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// testbench for the vector load/store unit
// memory and register file models, directed tests
////////////////////////////////////////////////////////////
module tb_lsu;
    import lsu_pkg::*;

    localparam int VREG_W     = 128;
    localparam int VMEM_W     = 32;
    localparam int REG_BYTES  = VREG_W / 8;
    // longest test takes well under 1000 cycles with room left for random stalls
    localparam int MAX_CYCLES = 4000;

    logic                   clk_i;
    logic                   async_rst_ni;
    logic                   op_valid_i;
    lsu_op_e                op_i;
    lsu_eew_e               eew_i;
    lsu_emul_e              emul_i;
    logic [7:0]             vl_i;
    logic                   vl_0_i;
    logic [ADDR_W-1:0]      base_addr_i;
    logic [VREG_ADDR_W-1:0] vd_i;
    logic                   op_ack_o;
    logic                   misaligned_o;
    logic                   pending_load_o;
    logic                   pending_store_o;
    logic [VREG_ADDR_W-1:0] vreg_rd_addr_o;
    logic [VREG_W-1:0]      vreg_rd_i;
    logic                   vreg_wr_en_o;
    logic [VREG_ADDR_W-1:0] vreg_wr_addr_o;
    logic [REG_BYTES-1:0]   vreg_wr_mask_o;
    logic [VREG_W-1:0]      vreg_wr_o;
    logic                   data_req_o;
    logic                   data_gnt_i;
    logic [ADDR_W-1:0]      data_addr_o;
    logic                   data_we_o;
    logic [VMEM_W/8-1:0]    data_be_o;
    logic [VMEM_W-1:0]      data_wdata_o;
    logic                   data_rvalid_i;
    logic [VMEM_W-1:0]      data_rdata_i;

    // models
    logic [7:0]        mem [256];
    logic [7:0]        mem_snap [256];
    logic [VREG_W-1:0] vregs [32];
    logic [VREG_W-1:0] vreg_snap [32];
    logic [31:0]       rd_q [$];
    int                due_q [$];
    int                seed = 89887;
    int                cycle_cnt = 0;
    int                last_due = 0;
    int                req_count = 0;
    int                wr_count = 0;
    int                errors = 0;
    int                checks = 0;
    int                tests = 0;
    logic [VREG_ADDR_W-1:0] rd_addr_seen = '0;

    // context of the running operation
    lsu_eew_e cur_eew;
    int       cur_vl;
    bit       cur_vl0;
    int       cur_vd;

    tb_clock_gen u_clock_gen (
        .clk_o  (clk_i),
        .rst_no (async_rst_ni)
    );

    lsu_top #(
        .VREG_W (VREG_W),
        .VMEM_W (VMEM_W)
    ) dut (
        .*
    );

    ////////////////////////////////////////////////////////////
    // reference and checks

    // tail rule for the byte at group position p
    function automatic bit ref_active(lsu_eew_e eew, int vl, bit vl0, int p);
        int ebytes;
        ebytes = (eew == EEW_32) ? 4 : ((eew == EEW_16) ? 2 : 1);
        return !vl0 && (p < vl * ebytes);
    endfunction

    task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %0h expected %0h", name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // memory and register file models that sample just before each rising edge

    always begin : model_proc
        int a;
        int k;
        int due;
        logic [REG_BYTES-1:0] exp_mask;
        @(negedge clk_i);
        cycle_cnt++;
        vreg_rd_i = vregs[rd_addr_seen];
        if (due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
            data_rvalid_i = 1'b1;
            data_rdata_i  = rd_q.pop_front();
            void'(due_q.pop_front());
        end else begin
            data_rvalid_i = 1'b0;
        end
        data_gnt_i = ($unsigned($random(seed)) % 4) != 0;
        #3;
        rd_addr_seen = vreg_rd_addr_o;
        if (data_req_o && data_gnt_i) begin
            req_count++;
            a = int'(data_addr_o[7:0]);
            if (data_we_o) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_be_o[b]) begin
                        mem[(a + b) % 256] = data_wdata_o[8*b +: 8];
                    end
                end
            end else begin
                due = cycle_cnt + 1 + int'($unsigned($random(seed)) % 4);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                rd_q.push_back({mem[(a + 3) % 256], mem[(a + 2) % 256],
                                mem[(a + 1) % 256], mem[a]});
                due_q.push_back(due);
            end
        end
        if (vreg_wr_en_o) begin
            wr_count++;
            k = int'(vreg_wr_addr_o) - cur_vd;
            for (int b = 0; b < REG_BYTES; b++) begin
                exp_mask[b] = ref_active(cur_eew, cur_vl, cur_vl0, k * REG_BYTES + b);
            end
            check_value("vreg_wr_mask_o", 128'(vreg_wr_mask_o), 128'(exp_mask));
            for (int b = 0; b < REG_BYTES; b++) begin
                if (vreg_wr_mask_o[b]) begin
                    vregs[vreg_wr_addr_o][8*b +: 8] = vreg_wr_o[8*b +: 8];
                end
            end
        end
    end

    initial begin : watchdog_proc
        wait (cycle_cnt > MAX_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // operation tasks

    task automatic run_op(lsu_op_e op, lsu_eew_e eew, lsu_emul_e emul, int vl, bit vl0,
                          int base, int vd, output bit mis);
        int reqs;
        int wrs;
        int nbeats;
        reqs   = req_count;
        wrs    = wr_count;
        nbeats = (1 << int'(emul)) * (VREG_W / VMEM_W);
        for (int i = 0; i < 256; i++) begin
            mem_snap[i] = mem[i];
        end
        for (int i = 0; i < 32; i++) begin
            vreg_snap[i] = vregs[i];
        end
        cur_eew = eew;
        cur_vl  = vl;
        cur_vl0 = vl0;
        cur_vd  = vd;
        @(negedge clk_i);
        op_valid_i  = 1'b1;
        op_i        = op;
        eew_i       = eew;
        emul_i      = emul;
        vl_i        = 8'(vl);
        vl_0_i      = vl0;
        base_addr_i = ADDR_W'(base);
        vd_i        = VREG_ADDR_W'(vd);
        #2;
        while (!op_ack_o) begin
            @(negedge clk_i);
            #2;
        end
        mis = misaligned_o;
        @(negedge clk_i);
        op_valid_i = 1'b0;
        #2;
        if (!mis) begin
            if (op == LSU_STORE) begin
                check_value("pending_store_o", 128'(pending_store_o), 128'(1));
            end else begin
                check_value("pending_load_o", 128'(pending_load_o), 128'(1));
            end
        end
        while (pending_load_o || pending_store_o) begin
            @(negedge clk_i);
            #2;
        end
        // once the flags drop every beat is granted and every load register written
        if (!mis) begin
            check_value("data_gnt_i grants", 128'(req_count - reqs), 128'(nbeats));
            if (op == LSU_LOAD) begin
                check_value("vreg_wr_en_o writes", 128'(wr_count - wrs),
                            128'(1 << int'(emul)));
            end
        end
    endtask

    task automatic store_test(lsu_eew_e eew, lsu_emul_e emul, int vl, bit vl0,
                              int base, int vd);
        bit mis;
        logic [7:0] exp;
        int nbytes;
        nbytes = REG_BYTES * (1 << int'(emul));
        run_op(LSU_STORE, eew, emul, vl, vl0, base, vd, mis);
        check_value("misaligned_o", 128'(mis), 128'(0));
        for (int a = 0; a < 256; a++) begin
            exp = mem_snap[a];
            if (a >= base && a < base + nbytes && ref_active(eew, vl, vl0, a - base)) begin
                exp = vreg_snap[vd + (a - base) / REG_BYTES][8*((a - base) % REG_BYTES) +: 8];
            end
            check_value($sformatf("mem[%02h]", a), 128'(mem[a]), 128'(exp));
        end
    endtask

    task automatic load_test(lsu_eew_e eew, lsu_emul_e emul, int vl, bit vl0,
                             int base, int vd);
        bit mis;
        logic [VREG_W-1:0] exp;
        int p;
        run_op(LSU_LOAD, eew, emul, vl, vl0, base, vd, mis);
        check_value("misaligned_o", 128'(mis), 128'(0));
        for (int r = 0; r < (1 << int'(emul)); r++) begin
            exp = vreg_snap[vd + r];
            for (int b = 0; b < REG_BYTES; b++) begin
                p = r * REG_BYTES + b;
                if (ref_active(eew, vl, vl0, p)) begin
                    exp[8*b +: 8] = mem_snap[(base + p) % 256];
                end
            end
            check_value($sformatf("vreg[%0d]", vd + r), vregs[vd + r], exp);
        end
    endtask

    task automatic misaligned_test(lsu_op_e op, int base);
        bit mis;
        int reqs;
        int wrs;
        reqs = req_count;
        wrs  = wr_count;
        run_op(op, EEW_8, EMUL_1, 8, 1'b0, base, 10, mis);
        check_value("misaligned_o", 128'(mis), 128'(1));
        repeat (10) @(negedge clk_i);
        if (req_count != reqs || wr_count != wrs) begin
            errors++;
            $display("misaligned operation made a memory request or a register write");
        end
    endtask

    task automatic end_test(string name, int err_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "failed");
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus

    initial begin : main_proc
        int e0;
        op_valid_i    = 1'b0;
        op_i          = LSU_LOAD;
        eew_i         = EEW_8;
        emul_i        = EMUL_1;
        vl_i          = 8'd0;
        vl_0_i        = 1'b0;
        base_addr_i   = '0;
        vd_i          = '0;
        vreg_rd_i     = '0;
        data_gnt_i    = 1'b0;
        data_rvalid_i = 1'b0;
        data_rdata_i  = '0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = 8'(a * 37 + 11) ^ 8'h5a;
        end
        for (int r = 0; r < 32; r++) begin
            for (int b = 0; b < REG_BYTES; b++) begin
                vregs[r][8*b +: 8] = 8'((r * REG_BYTES + b) * 7 + 3);
            end
        end
        wait (async_rst_ni === 1'b1);
        @(negedge clk_i);

        e0 = errors;
        store_test(EEW_8, EMUL_1, 16, 1'b0, 'h00, 1);
        end_test("store emul 1 full vl", e0);

        e0 = errors;
        store_test(EEW_8, EMUL_1, 5, 1'b0, 'h80, 2);
        store_test(EEW_16, EMUL_1, 3, 1'b0, 'h90, 3);
        store_test(EEW_32, EMUL_2, 6, 1'b0, 'hA0, 4);
        store_test(EEW_8, EMUL_1, 4, 1'b1, 'hC0, 5);
        end_test("store partial vl and vl_0", e0);

        e0 = errors;
        load_test(EEW_16, EMUL_2, 11, 1'b0, 'h20, 8);
        end_test("load emul 2", e0);

        e0 = errors;
        load_test(EEW_32, EMUL_8, 30, 1'b0, 'h40, 16);
        end_test("load emul 8 random timing", e0);

        e0 = errors;
        misaligned_test(LSU_STORE, 'h13);
        misaligned_test(LSU_LOAD, 'h22);
        end_test("misaligned base", e0);

        e0 = errors;
        store_test(EEW_16, EMUL_4, 20, 1'b0, 'h00, 0);
        load_test(EEW_8, EMUL_1, 9, 1'b0, 'h30, 12);
        end_test("pending flags", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// testbench clock and reset source
////////////////////////////////////////////////////////////
module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);
    localparam int HALF_PERIOD = 4;
    localparam int RST_CYCLES  = 16;

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        // release away from the active edge
        @(negedge clk_o);
        rst_no = 1'b1;
    end

    always #HALF_PERIOD clk_o = ~clk_o;

endmodule

/* logic/lsu_top.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// vector load/store unit top level
////////////////////////////////////////////////////////////
module lsu_top #(
    parameter int unsigned VREG_W = 128,
    parameter int unsigned VMEM_W = 32
) (
    input  logic                            clk_i,
    input  logic                            async_rst_ni,
    input  logic                            op_valid_i,
    input  lsu_pkg::lsu_op_e                op_i,
    input  lsu_pkg::lsu_eew_e               eew_i,
    input  lsu_pkg::lsu_emul_e              emul_i,
    input  logic [7:0]                      vl_i,
    input  logic                            vl_0_i,
    input  logic [lsu_pkg::ADDR_W-1:0]      base_addr_i,
    input  logic [lsu_pkg::VREG_ADDR_W-1:0] vd_i,
    output logic                            op_ack_o,
    output logic                            misaligned_o,
    output logic                            pending_load_o,
    output logic                            pending_store_o,
    output logic [lsu_pkg::VREG_ADDR_W-1:0] vreg_rd_addr_o,
    input  logic [VREG_W-1:0]               vreg_rd_i,
    output logic                            vreg_wr_en_o,
    output logic [lsu_pkg::VREG_ADDR_W-1:0] vreg_wr_addr_o,
    output logic [VREG_W/8-1:0]             vreg_wr_mask_o,
    output logic [VREG_W-1:0]               vreg_wr_o,
    output logic                            data_req_o,
    input  logic                            data_gnt_i,
    output logic [lsu_pkg::ADDR_W-1:0]      data_addr_o,
    output logic                            data_we_o,
    output logic [VMEM_W/8-1:0]             data_be_o,
    output logic [VMEM_W-1:0]               data_wdata_o,
    input  logic                            data_rvalid_i,
    input  logic [VMEM_W-1:0]               data_rdata_i
);
    import lsu_pkg::*;

    // sequencer to request stage
    logic                   seq_valid;
    logic                   req_ready;
    logic [ADDR_W-1:0]      beat_addr;
    lsu_op_e                beat_op;
    logic [VREG_ADDR_W-1:0] beat_vreg;
    logic                   beat_first;
    logic                   beat_last;
    logic [VMEM_W/8-1:0]    beat_be;
    logic                   busy;
    lsu_op_e                busy_op;

    // request stage to write-back
    logic                   credit_return;
    logic                   ld_entry_valid;
    logic [VREG_ADDR_W-1:0] ld_vreg;
    logic [VMEM_W/8-1:0]    ld_be;
    logic                   ld_last;

    lsu_sequencer #(
        .VREG_W (VREG_W),
        .VMEM_W (VMEM_W)
    ) u_sequencer (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_valid_i     (op_valid_i),
        .op_i           (op_i),
        .eew_i          (eew_i),
        .emul_i         (emul_i),
        .vl_i           (vl_i),
        .vl_0_i         (vl_0_i),
        .base_addr_i    (base_addr_i),
        .vd_i           (vd_i),
        .op_ack_o       (op_ack_o),
        .misaligned_o   (misaligned_o),
        .seq_valid_o    (seq_valid),
        .req_ready_i    (req_ready),
        .beat_addr_o    (beat_addr),
        .beat_op_o      (beat_op),
        .beat_vreg_o    (beat_vreg),
        .beat_first_o   (beat_first),
        .beat_last_o    (beat_last),
        .beat_be_o      (beat_be),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .busy_o         (busy),
        .busy_op_o      (busy_op)
    );

    lsu_request #(
        .VREG_W (VREG_W),
        .VMEM_W (VMEM_W)
    ) u_request (
        .clk_i            (clk_i),
        .async_rst_ni     (async_rst_ni),
        .seq_valid_i      (seq_valid),
        .beat_addr_i      (beat_addr),
        .beat_op_i        (beat_op),
        .beat_vreg_i      (beat_vreg),
        .beat_first_i     (beat_first),
        .beat_last_i      (beat_last),
        .beat_be_i        (beat_be),
        .vreg_rd_i        (vreg_rd_i),
        .req_ready_o      (req_ready),
        .busy_i           (busy),
        .busy_op_i        (busy_op),
        .data_req_o       (data_req_o),
        .data_gnt_i       (data_gnt_i),
        .data_addr_o      (data_addr_o),
        .data_we_o        (data_we_o),
        .data_be_o        (data_be_o),
        .data_wdata_o     (data_wdata_o),
        .credit_return_i  (credit_return),
        .ld_entry_valid_o (ld_entry_valid),
        .ld_vreg_o        (ld_vreg),
        .ld_be_o          (ld_be),
        .ld_last_o        (ld_last),
        .ld_pending_o     (pending_load_o),
        .st_pending_o     (pending_store_o)
    );

    lsu_writeback #(
        .VREG_W (VREG_W),
        .VMEM_W (VMEM_W)
    ) u_writeback (
        .clk_i            (clk_i),
        .async_rst_ni     (async_rst_ni),
        .data_rvalid_i    (data_rvalid_i),
        .data_rdata_i     (data_rdata_i),
        .ld_entry_valid_i (ld_entry_valid),
        .ld_vreg_i        (ld_vreg),
        .ld_be_i          (ld_be),
        .ld_last_i        (ld_last),
        .credit_return_o  (credit_return),
        .vreg_wr_en_o     (vreg_wr_en_o),
        .vreg_wr_addr_o   (vreg_wr_addr_o),
        .vreg_wr_mask_o   (vreg_wr_mask_o),
        .vreg_wr_o        (vreg_wr_o)
    );

endmodule

/* logic/lsu_writeback.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// vector LSU load write-back
// assembles read beats into a register and writes it back
////////////////////////////////////////////////////////////
module lsu_writeback #(
    parameter int unsigned VREG_W = 128,
    parameter int unsigned VMEM_W = 32
) (
    input  logic                            clk_i,
    input  logic                            async_rst_ni,
    input  logic                            data_rvalid_i,
    input  logic [VMEM_W-1:0]               data_rdata_i,
    input  logic                            ld_entry_valid_i,
    input  logic [lsu_pkg::VREG_ADDR_W-1:0] ld_vreg_i,
    input  logic [VMEM_W/8-1:0]             ld_be_i,
    input  logic                            ld_last_i,
    output logic                            credit_return_o,
    output logic                            vreg_wr_en_o,
    output logic [lsu_pkg::VREG_ADDR_W-1:0] vreg_wr_addr_o,
    output logic [VREG_W/8-1:0]             vreg_wr_mask_o,
    output logic [VREG_W-1:0]               vreg_wr_o
);
    import lsu_pkg::*;

    localparam int unsigned BEAT_BYTES = VMEM_W / 8;
    localparam int unsigned REG_BYTES  = VREG_W / 8;

    logic                   rvalid_q;
    logic [VMEM_W-1:0]      rdata_q;
    logic [VREG_W-1:0]      asm_q;
    logic [REG_BYTES-1:0]   mask_q;
    logic [REG_BYTES-1:0]   mask_base;
    logic                   wr_en_q;
    logic [VREG_ADDR_W-1:0] wr_addr_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            rvalid_q <= 1'b0;
            wr_en_q  <= 1'b0;
        end else begin
            rvalid_q <= data_rvalid_i;
            wr_en_q  <= rvalid_q && ld_last_i;
        end
    end

    // the mask starts over once a register has been written
    assign mask_base = wr_en_q ? '0 : mask_q;

    always_ff @(posedge clk_i) begin
        if (data_rvalid_i) begin
            rdata_q <= data_rdata_i;
        end
        if (rvalid_q) begin
            // beats arrive lowest first and shift down from the top
            asm_q     <= {rdata_q, asm_q[VREG_W-1:VMEM_W]};
            mask_q    <= {ld_be_i, mask_base[REG_BYTES-1:BEAT_BYTES]};
            wr_addr_q <= ld_vreg_i;
        end else if (wr_en_q) begin
            mask_q <= '0;
        end
    end

    // the head entry is released together with its beat
    assign credit_return_o = rvalid_q;

    assign vreg_wr_en_o   = wr_en_q;
    assign vreg_wr_addr_o = wr_addr_q;
    assign vreg_wr_mask_o = mask_q;
    assign vreg_wr_o      = asm_q;

    rvalid_entry_a: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        data_rvalid_i |-> ld_entry_valid_i);

endmodule

/* logic/lsu_request.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// vector LSU memory request stage
// issues beats on the memory port and tracks load credits
////////////////////////////////////////////////////////////
module lsu_request #(
    parameter int unsigned VREG_W = 128,
    parameter int unsigned VMEM_W = 32
) (
    input  logic                            clk_i,
    input  logic                            async_rst_ni,
    input  logic                            seq_valid_i,
    input  logic [lsu_pkg::ADDR_W-1:0]      beat_addr_i,
    input  lsu_pkg::lsu_op_e                beat_op_i,
    input  logic [lsu_pkg::VREG_ADDR_W-1:0] beat_vreg_i,
    input  logic                            beat_first_i,
    input  logic                            beat_last_i,
    input  logic [VMEM_W/8-1:0]             beat_be_i,
    input  logic [VREG_W-1:0]               vreg_rd_i,
    output logic                            req_ready_o,
    input  logic                            busy_i,
    input  lsu_pkg::lsu_op_e                busy_op_i,
    output logic                            data_req_o,
    input  logic                            data_gnt_i,
    output logic [lsu_pkg::ADDR_W-1:0]      data_addr_o,
    output logic                            data_we_o,
    output logic [VMEM_W/8-1:0]             data_be_o,
    output logic [VMEM_W-1:0]               data_wdata_o,
    input  logic                            credit_return_i,
    output logic                            ld_entry_valid_o,
    output logic [lsu_pkg::VREG_ADDR_W-1:0] ld_vreg_o,
    output logic [VMEM_W/8-1:0]             ld_be_o,
    output logic                            ld_last_o,
    output logic                            ld_pending_o,
    output logic                            st_pending_o
);
    import lsu_pkg::*;

    localparam int unsigned CRED_W = $clog2(LOAD_CREDITS + 1);
    localparam int unsigned PTR_W  = $clog2(LOAD_CREDITS);

    logic                   req_valid_q;
    logic [ADDR_W-1:0]      addr_q;
    lsu_op_e                op_q;
    logic [VREG_ADDR_W-1:0] vreg_q;
    logic                   last_q;
    logic [VMEM_W/8-1:0]    be_q;
    logic                   accept;
    logic                   ld_grant;

    // store data of the current register
    logic                   fill_q;
    logic [VREG_W-1:0]      wdata_sr_q;
    logic [VREG_W-1:0]      wdata_src;

    // load credits and the pending load queue
    logic [CRED_W-1:0]      credits_q;
    logic [PTR_W-1:0]       wr_ptr_q;
    logic [PTR_W-1:0]       rd_ptr_q;
    logic                   ret_q;
    logic [VREG_ADDR_W-1:0] q_vreg [LOAD_CREDITS];
    logic [VMEM_W/8-1:0]    q_be   [LOAD_CREDITS];
    logic                   q_last [LOAD_CREDITS];

    ////////////////////////////////////////////////////////////
    // request register

    assign accept      = data_req_o && data_gnt_i;
    assign ld_grant    = accept && (op_q == LSU_LOAD);
    assign req_ready_o = !req_valid_q || accept;

    // loads wait for a free credit
    assign data_req_o  = req_valid_q && ((op_q == LSU_STORE) || (credits_q != '0));

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            req_valid_q <= 1'b0;
            fill_q      <= 1'b0;
        end else begin
            if (req_ready_o) begin
                req_valid_q <= seq_valid_i;
            end
            // the register file answers one cycle after the first store beat
            fill_q <= req_ready_o && seq_valid_i && beat_first_i && (beat_op_i == LSU_STORE);
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_ready_o) begin
            addr_q <= beat_addr_i;
            op_q   <= beat_op_i;
            vreg_q <= beat_vreg_i;
            last_q <= beat_last_i;
            be_q   <= beat_be_i;
        end
        if (accept && (op_q == LSU_STORE)) begin
            wdata_sr_q <= wdata_src >> VMEM_W;
        end else if (fill_q) begin
            wdata_sr_q <= vreg_rd_i;
        end
    end

    assign wdata_src    = fill_q ? vreg_rd_i : wdata_sr_q;
    assign data_addr_o  = addr_q;
    assign data_we_o    = op_q == LSU_STORE;
    assign data_be_o    = be_q;
    assign data_wdata_o = wdata_src[VMEM_W-1:0];

    ////////////////////////////////////////////////////////////
    // load credits

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            credits_q <= CRED_W'(LOAD_CREDITS);
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            ret_q     <= 1'b0;
        end else begin
            ret_q <= credit_return_i;
            if (ld_grant) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (credit_return_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (ld_grant && !credit_return_i) begin
                credits_q <= credits_q - 1'b1;
            end else if (!ld_grant && credit_return_i) begin
                credits_q <= credits_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ld_grant) begin
            q_vreg[wr_ptr_q] <= vreg_q;
            q_be[wr_ptr_q]   <= be_q;
            q_last[wr_ptr_q] <= last_q;
        end
    end

    // every spent credit is one queued entry
    assign ld_entry_valid_o = credits_q != CRED_W'(LOAD_CREDITS);
    assign ld_vreg_o        = q_vreg[rd_ptr_q];
    assign ld_be_o          = q_be[rd_ptr_q];
    assign ld_last_o        = q_last[rd_ptr_q];

    // ret_q covers the cycle of the final register write
    assign ld_pending_o = (busy_i && (busy_op_i == LSU_LOAD)) ||
                          (req_valid_q && (op_q == LSU_LOAD)) ||
                          ld_entry_valid_o || ret_q;
    assign st_pending_o = (busy_i && (busy_op_i == LSU_STORE)) ||
                          (req_valid_q && (op_q == LSU_STORE));

    credit_bound_a: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        credits_q <= CRED_W'(LOAD_CREDITS));

    req_hold_a: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) &&
            $stable(data_we_o) && $stable(data_be_o) && $stable(data_wdata_o));

endmodule

/* logic/lsu_sequencer.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// vector LSU operation sequencer
// accepts unit-stride operations and walks the memory beats
// of the register group
////////////////////////////////////////////////////////////
module lsu_sequencer #(
    parameter int unsigned VREG_W = 128,
    parameter int unsigned VMEM_W = 32
) (
    input  logic                            clk_i,
    input  logic                            async_rst_ni,
    input  logic                            op_valid_i,
    input  lsu_pkg::lsu_op_e                op_i,
    input  lsu_pkg::lsu_eew_e               eew_i,
    input  lsu_pkg::lsu_emul_e              emul_i,
    input  logic [7:0]                      vl_i,
    input  logic                            vl_0_i,
    input  logic [lsu_pkg::ADDR_W-1:0]      base_addr_i,
    input  logic [lsu_pkg::VREG_ADDR_W-1:0] vd_i,
    output logic                            op_ack_o,
    output logic                            misaligned_o,
    output logic                            seq_valid_o,
    input  logic                            req_ready_i,
    output logic [lsu_pkg::ADDR_W-1:0]      beat_addr_o,
    output lsu_pkg::lsu_op_e                beat_op_o,
    output logic [lsu_pkg::VREG_ADDR_W-1:0] beat_vreg_o,
    output logic                            beat_first_o,
    output logic                            beat_last_o,
    output logic [VMEM_W/8-1:0]             beat_be_o,
    output logic [lsu_pkg::VREG_ADDR_W-1:0] vreg_rd_addr_o,
    output logic                            busy_o,
    output lsu_pkg::lsu_op_e                busy_op_o
);
    import lsu_pkg::*;

    localparam int unsigned BEAT_BYTES    = VMEM_W / 8;
    localparam int unsigned BEATS_PER_REG = VREG_W / VMEM_W;
    localparam int unsigned OFS_W         = $clog2(BEAT_BYTES);
    localparam int unsigned SUB_W         = $clog2(BEATS_PER_REG);
    // up to 8 registers per group
    localparam int unsigned CNT_W         = SUB_W + 3;
    localparam int unsigned POS_W         = CNT_W + OFS_W;
    // vl times 4 needs 10 bits
    localparam int unsigned ACT_W         = (POS_W > 10) ? POS_W : 10;

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } seq_state_e;

    seq_state_e             state_q;
    logic [CNT_W-1:0]       cnt_q;
    logic [CNT_W-1:0]       last_cnt_q;
    logic [CNT_W-1:0]       last_cnt_d;
    logic [ACT_W-1:0]       active_q;
    logic [ACT_W-1:0]       active_d;
    logic [ADDR_W-1:0]      addr_q;
    logic [VREG_ADDR_W-1:0] vreg_q;
    lsu_op_e                op_q;
    logic                   misaligned;
    logic                   beat_done;
    logic                   group_done;

    ////////////////////////////////////////////////////////////
    // operation decode

    assign misaligned = base_addr_i[OFS_W-1:0] != '0;

    // index of the final beat of the group
    always_comb begin
        unique case (emul_i)
            EMUL_1: last_cnt_d = CNT_W'(BEATS_PER_REG - 1);
            EMUL_2: last_cnt_d = CNT_W'(2 * BEATS_PER_REG - 1);
            EMUL_4: last_cnt_d = CNT_W'(4 * BEATS_PER_REG - 1);
            EMUL_8: last_cnt_d = CNT_W'(8 * BEATS_PER_REG - 1);
        endcase
    end

    // active bytes of the group are vl times the element bytes
    always_comb begin
        unique case (eew_i)
            EEW_16:  active_d = ACT_W'({vl_i, 1'b0});
            EEW_32:  active_d = ACT_W'({vl_i, 2'b00});
            default: active_d = ACT_W'(vl_i);
        endcase
        if (vl_0_i) begin
            active_d = '0;
        end
    end

    assign op_ack_o     = op_valid_i && (state_q == ST_IDLE);
    assign misaligned_o = op_ack_o && misaligned;

    ////////////////////////////////////////////////////////////
    // beat stepping

    assign seq_valid_o = state_q == ST_BUSY;
    assign beat_done   = seq_valid_o && req_ready_i;
    assign group_done  = cnt_q == last_cnt_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else if (op_ack_o && !misaligned) begin
            state_q <= ST_BUSY;
            cnt_q   <= '0;
        end else if (beat_done) begin
            state_q <= group_done ? ST_IDLE : ST_BUSY;
            cnt_q   <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (op_ack_o) begin
            addr_q     <= base_addr_i;
            vreg_q     <= vd_i;
            op_q       <= op_i;
            last_cnt_q <= last_cnt_d;
            active_q   <= active_d;
        end else if (beat_done) begin
            addr_q <= addr_q + ADDR_W'(BEAT_BYTES);
            // next register of the group
            if (beat_last_o) begin
                vreg_q <= vreg_q + 1'b1;
            end
        end
    end

    assign beat_addr_o    = addr_q;
    assign beat_op_o      = op_q;
    assign beat_vreg_o    = vreg_q;
    assign beat_first_o   = cnt_q[SUB_W-1:0] == '0;
    assign beat_last_o    = cnt_q[SUB_W-1:0] == '1;
    assign vreg_rd_addr_o = vreg_q;
    assign busy_o         = seq_valid_o;
    assign busy_op_o      = op_q;

    // tail rule compares the byte position in the group with the active count
    always_comb begin
        for (int unsigned i = 0; i < BEAT_BYTES; i++) begin
            beat_be_o[i] = ACT_W'({cnt_q, OFS_W'(i)}) < active_q;
        end
    end

    // a rejected base never reaches the beat stream
    beat_aligned_a: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        seq_valid_o |-> beat_addr_o[OFS_W-1:0] == '0);

endmodule

/* logic/lsu_pkg.sv */
////////////////////////////////////////////////////////////
// vector load/store unit shared types and constants
// element widths, register group sizes and opcodes
////////////////////////////////////////////////////////////
package lsu_pkg;

    // memory address width
    localparam int unsigned ADDR_W = 32;

    // vector register index width
    localparam int unsigned VREG_ADDR_W = 5;

    // granted loads that may still wait for read data
    localparam int unsigned LOAD_CREDITS = 4;

    // element width encoded as log2 of the element bytes
    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } lsu_eew_e;

    // register group size encoded as log2 of the register count
    typedef enum logic [1:0] {
        EMUL_1 = 2'd0,
        EMUL_2 = 2'd1,
        EMUL_4 = 2'd2,
        EMUL_8 = 2'd3
    } lsu_emul_e;

    typedef enum logic {
        LSU_LOAD  = 1'b0,
        LSU_STORE = 1'b1
    } lsu_op_e;

endpackage
